// ==== source/arm_pkg.sv ====
`default_nettype none

package arm_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;

	// condition flags, same order as the top nibble of the cpsr
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	typedef enum logic [1:0] {
		st_init   = 2'd0,
		st_fetch  = 2'd1,
		st_decode = 2'd2,
		st_exec   = 2'd3
	} cpu_state_t;

	// data-processing opcodes, instr[24:21]
	typedef enum logic [3:0] {
		op_and, op_eor, op_sub, op_rsb,
		op_add, op_adc, op_sbc, op_rsc,
		op_tst, op_teq, op_cmp, op_cmn,
		op_orr, op_mov, op_bic, op_mvn
	} alu_op_t;

	// condition field, instr[31:28]; 4'hf is left out
	typedef enum logic [3:0] {
		cond_eq, cond_ne, cond_cs, cond_cc,
		cond_mi, cond_pl, cond_vs, cond_vc,
		cond_hi, cond_ls, cond_ge, cond_lt,
		cond_gt, cond_le, cond_al
	} cond_t;

	typedef enum logic [1:0] {
		w_byte = 2'd0,
		w_word = 2'd2
	} width_t;

	typedef struct packed {
		word_t  value;
		flags_t flags;
		logic   wr;	// low for tst, teq, cmp, cmn
	} dp_result_t;

	typedef struct packed {
		logic   valid;
		logic   load;
		width_t width;
		word_t  addr;
	} ls_req_t;

	localparam word_t pc_step = 32'd4;
	localparam word_t pc_read_ahead = 32'd8;	// r15 reads see two instructions ahead

endpackage

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic              clk,
	input  arm_pkg::reg_idx_t rn_idx,
	input  arm_pkg::reg_idx_t rm_idx,
	input  arm_pkg::reg_idx_t rd_idx,
	input  arm_pkg::word_t    pc,
	output arm_pkg::word_t    rn_val,
	output arm_pkg::word_t    rm_val,
	output arm_pkg::word_t    rd_val,
	input  logic              wr_en,
	input  arm_pkg::reg_idx_t wr_idx,
	input  arm_pkg::word_t    wr_data
);
	import arm_pkg::*;

	word_t regs [0:14];	// r0 .. r14

	// index 15 reads the pc two instructions ahead
	assign rn_val = (rn_idx == 4'd15) ? pc + pc_read_ahead : regs[rn_idx];
	assign rm_val = (rm_idx == 4'd15) ? pc + pc_read_ahead : regs[rm_idx];
	assign rd_val = (rd_idx == 4'd15) ? pc + pc_read_ahead : regs[rd_idx];

	// pc writes are handled by the control unit
	always_ff @(posedge clk) begin
		if (wr_en && wr_idx != 4'd15)
			regs[wr_idx] <= wr_data;
	end

endmodule

`default_nettype wire

// ==== source/dp_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module dp_unit (
	input  arm_pkg::word_t      instr,
	input  arm_pkg::word_t      rn_val,
	input  arm_pkg::word_t      rm_val,
	input  arm_pkg::flags_t     flags,
	output arm_pkg::dp_result_t result
);
	import arm_pkg::*;

	alu_op_t     op;
	logic [4:0]  amt;
	logic [4:0]  rot;
	word_t       op2;
	logic        op2_c;
	logic [32:0] sh;
	word_t       x;
	word_t       y;
	logic        cin;
	logic        arith;
	word_t       lv;
	logic [32:0] sum;
	word_t       value;

	function automatic word_t ror32(input word_t a, input logic [4:0] n);
		logic [63:0] d;
		d = {a, a} >> n;
		return d[31:0];
	endfunction

	assign op = alu_op_t'(instr[24:21]);
	assign amt = instr[11:7];
	assign rot = {instr[11:8], 1'b0};

	// shifter operand
	always_comb begin
		sh = '0;
		op2 = rm_val;
		op2_c = flags.c;
		if (instr[25]) begin
			op2 = ror32({24'b0, instr[7:0]}, rot);
			if (rot != 5'd0)
				op2_c = op2[31];
		end else begin
			case (instr[6:5])
				2'b00: if (amt != 5'd0) begin	// lsl
					sh = {1'b0, rm_val} << amt;
					op2 = sh[31:0];
					op2_c = sh[32];
				end
				2'b01: if (amt == 5'd0) begin	// lsr #32
					op2 = '0;
					op2_c = rm_val[31];
				end else begin
					sh = {rm_val, 1'b0} >> amt;
					op2 = sh[32:1];
					op2_c = sh[0];
				end
				2'b10: if (amt == 5'd0) begin	// asr #32
					op2 = {32{rm_val[31]}};
					op2_c = rm_val[31];
				end else begin
					sh = $signed({rm_val, 1'b0}) >>> amt;
					op2 = sh[32:1];
					op2_c = sh[0];
				end
				default: if (amt == 5'd0) begin	// rrx
					op2 = {flags.c, rm_val[31:1]};
					op2_c = rm_val[0];
				end else begin
					op2 = ror32(rm_val, amt);
					op2_c = op2[31];
				end
			endcase
		end
	end

	// alu, subtracts run as x + ~y + carry
	always_comb begin
		x = rn_val;
		y = op2;
		cin = 1'b0;
		arith = 1'b1;
		lv = '0;
		case (op)
			op_and, op_tst: begin lv = rn_val & op2; arith = 1'b0; end
			op_eor, op_teq: begin lv = rn_val ^ op2; arith = 1'b0; end
			op_orr: begin lv = rn_val | op2; arith = 1'b0; end
			op_mov: begin lv = op2; arith = 1'b0; end
			op_bic: begin lv = rn_val & ~op2; arith = 1'b0; end
			op_mvn: begin lv = ~op2; arith = 1'b0; end
			op_sub, op_cmp: begin y = ~op2; cin = 1'b1; end
			op_rsb: begin x = op2; y = ~rn_val; cin = 1'b1; end
			op_adc: cin = flags.c;
			op_sbc: begin y = ~op2; cin = flags.c; end
			op_rsc: begin x = op2; y = ~rn_val; cin = flags.c; end
			default: ;	// add, cmn
		endcase
		sum = {1'b0, x} + {1'b0, y} + {32'b0, cin};
		value = arith ? sum[31:0] : lv;

		result.value = value;
		result.flags.n = value[31];
		result.flags.z = value == 32'd0;
		result.flags.c = arith ? sum[32] : op2_c;
		result.flags.v = arith ? (x[31] == y[31]) && (sum[31] != x[31]) : flags.v;
		result.wr = instr[24:23] != 2'b10;	// test and compare ops
	end

endmodule

`default_nettype wire

// ==== source/ls_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ls_unit (
	input  arm_pkg::word_t   instr,
	input  arm_pkg::word_t   rn_val,
	input  arm_pkg::word_t   rm_val,
	input  arm_pkg::word_t   mem_rdata,
	output arm_pkg::ls_req_t req,
	output arm_pkg::word_t   load_val
);
	import arm_pkg::*;

	word_t offset;
	logic  is_byte;

	// i bit set means register offset in mode 2
	assign offset = instr[25] ? rm_val : {20'b0, instr[11:0]};
	assign is_byte = instr[22];

	always_comb begin
		req.valid = instr[27:26] == 2'b01;
		req.load = instr[20];
		req.width = is_byte ? w_byte : w_word;
		req.addr = instr[23] ? rn_val + offset : rn_val - offset;	// pre-indexed only
	end

	// byte loads come back in the low lane
	assign load_val = is_byte ? {24'b0, mem_rdata[7:0]} : mem_rdata;

endmodule

`default_nettype wire

// ==== source/cpu_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_control #(
	parameter arm_pkg::word_t reset_pc = 32'h0800_0000
) (
	input  logic                clk,
	input  logic                rstn,
	output arm_pkg::word_t      instr,
	output arm_pkg::word_t      pc,
	output arm_pkg::flags_t     flags,
	output arm_pkg::reg_idx_t   rn_idx,
	output arm_pkg::reg_idx_t   rm_idx,
	output arm_pkg::reg_idx_t   rd_idx,
	input  arm_pkg::dp_result_t dp,
	input  arm_pkg::ls_req_t    ls,
	input  arm_pkg::word_t      load_val,
	input  arm_pkg::word_t      rd_val,
	output logic                wr_en,
	output arm_pkg::reg_idx_t   wr_idx,
	output arm_pkg::word_t      wr_data,
	output arm_pkg::word_t      mem_addr,
	output arm_pkg::word_t      mem_wdata,
	output arm_pkg::width_t     mem_width,
	output logic                mem_read,
	output logic                mem_write,
	input  arm_pkg::word_t      mem_rdata,
	input  logic                mem_ok
);
	import arm_pkg::*;

	cpu_state_t state;
	cpu_state_t state_nx;
	word_t      pc_nx;
	flags_t     flags_nx;
	logic       ir_load;
	logic       cond_ok;
	logic       is_branch;
	logic       is_dp;
	word_t      br_offset;

	function automatic logic cond_pass(input cond_t c, input flags_t f);
		case (c)
			cond_eq: return f.z;
			cond_ne: return !f.z;
			cond_cs: return f.c;
			cond_cc: return !f.c;
			cond_mi: return f.n;
			cond_pl: return !f.n;
			cond_vs: return f.v;
			cond_vc: return !f.v;
			cond_hi: return f.c && !f.z;
			cond_ls: return !f.c || f.z;
			cond_ge: return f.n == f.v;
			cond_lt: return f.n != f.v;
			cond_gt: return !f.z && (f.n == f.v);
			cond_le: return f.z || (f.n != f.v);
			cond_al: return 1'b1;
			default: return 1'b0;	// nv never executes
		endcase
	endfunction

	assign rn_idx = instr[19:16];
	assign rm_idx = instr[3:0];
	assign rd_idx = instr[15:12];

	assign cond_ok = cond_pass(cond_t'(instr[31:28]), flags);
	assign is_branch = instr[27:25] == 3'b101;
	assign is_dp = instr[27:26] == 2'b00;
	assign br_offset = {{6{instr[23]}}, instr[23:0], 2'b00};

	assign mem_wdata = rd_val;	// stores always take rd

	always_comb begin
		state_nx = state;
		pc_nx = pc;
		flags_nx = flags;
		ir_load = 1'b0;
		wr_en = 1'b0;
		wr_idx = rd_idx;
		wr_data = dp.value;
		mem_addr = pc;
		mem_width = w_word;
		mem_read = 1'b0;
		mem_write = 1'b0;

		// an unknown state falls to default, so the strobes stay low
		case (state)
			st_init: begin
				pc_nx = reset_pc;
				flags_nx = '0;
				state_nx = st_fetch;
			end
			st_fetch: begin
				mem_read = 1'b1;
				if (mem_ok) begin
					ir_load = 1'b1;
					state_nx = st_decode;
				end
			end
			st_decode: state_nx = st_exec;
			st_exec: begin
				pc_nx = pc + pc_step;
				if (cond_ok && is_branch) begin
					pc_nx = pc + pc_read_ahead + br_offset;
					if (instr[24]) begin	// bl
						wr_en = 1'b1;
						wr_idx = 4'd14;
						wr_data = pc + pc_step;
					end
				end else if (cond_ok && ls.valid) begin
					mem_addr = ls.addr;
					mem_width = ls.width;
					mem_read = ls.load;
					mem_write = !ls.load;
					wr_en = ls.load;
					wr_data = load_val;
				end else if (cond_ok && is_dp) begin
					wr_en = dp.wr;
					if (instr[20])
						flags_nx = dp.flags;
				end

				// r15 lives here, not in the register file
				if (wr_en && wr_idx == 4'd15) begin
					pc_nx = {wr_data[31:2], 2'b00};
					wr_en = 1'b0;
				end

				// hold everything while the data access waits
				if ((mem_read || mem_write) && !mem_ok) begin
					wr_en = 1'b0;
					pc_nx = pc;
					flags_nx = flags;
				end else begin
					state_nx = st_fetch;
				end
			end
			default: state_nx = st_init;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_init;
			pc <= reset_pc;
			flags <= '0;
		end else begin
			state <= state_nx;
			pc <= pc_nx;
			flags <= flags_nx;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_load)
			instr <= mem_rdata;
	end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
	parameter arm_pkg::word_t reset_pc = 32'h0800_0000
) (
	input  logic            clk,
	input  logic            rstn,
	output arm_pkg::word_t  mem_addr,
	output arm_pkg::word_t  mem_wdata,
	input  arm_pkg::word_t  mem_rdata,
	output arm_pkg::width_t mem_width,
	output logic            mem_read,
	output logic            mem_write,
	input  logic            mem_ok
);
	import arm_pkg::*;

	word_t      instr;
	word_t      pc;
	flags_t     flags;
	reg_idx_t   rn_idx;
	reg_idx_t   rm_idx;
	reg_idx_t   rd_idx;
	word_t      rn_val;
	word_t      rm_val;
	word_t      rd_val;
	dp_result_t dp;
	ls_req_t    ls;
	word_t      load_val;
	logic       wr_en;
	reg_idx_t   wr_idx;
	word_t      wr_data;

	cpu_control #(
		.reset_pc(reset_pc)
	) u_control (
		.clk(clk),
		.rstn(rstn),
		.instr(instr),
		.pc(pc),
		.flags(flags),
		.rn_idx(rn_idx),
		.rm_idx(rm_idx),
		.rd_idx(rd_idx),
		.dp(dp),
		.ls(ls),
		.load_val(load_val),
		.rd_val(rd_val),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_width(mem_width),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_rdata(mem_rdata),
		.mem_ok(mem_ok)
	);

	reg_file u_regs (
		.clk(clk),
		.rn_idx(rn_idx),
		.rm_idx(rm_idx),
		.rd_idx(rd_idx),
		.pc(pc),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.rd_val(rd_val),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

	dp_unit u_dp (
		.instr(instr),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.flags(flags),
		.result(dp)
	);

	ls_unit u_ls (
		.instr(instr),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.mem_rdata(mem_rdata),
		.req(ls),
		.load_val(load_val)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int period = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== tests/cpu_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_sva (
	input logic            clk,
	input logic            rstn,
	input arm_pkg::word_t  mem_addr,
	input arm_pkg::width_t mem_width,
	input logic            mem_read,
	input logic            mem_write,
	input logic            mem_ok
);

	int unsigned fails = 0;	// read by the testbench at the end

	a_one_strobe: assert property (@(posedge clk) !(mem_read && mem_write))
		else begin
			fails++;
			$error("mem_read and mem_write are high together");
		end

	// a pending access keeps its strobe, address and width
	a_read_hold: assert property (@(posedge clk) disable iff (!rstn)
		mem_read && !mem_ok |=> mem_read && $stable(mem_addr) && $stable(mem_width))
		else begin
			fails++;
			$error("mem_read or its address dropped before mem_ok");
		end

	a_write_hold: assert property (@(posedge clk) disable iff (!rstn)
		mem_write && !mem_ok |=> mem_write && $stable(mem_addr) && $stable(mem_width))
		else begin
			fails++;
			$error("mem_write or its address dropped before mem_ok");
		end

	a_reset_quiet: assert property (@(posedge clk) !rstn |-> !mem_read && !mem_write)
		else begin
			fails++;
			$error("bus strobe high while rstn is low");
		end

endmodule

bind cpu_top cpu_sva u_sva (
	.clk(clk),
	.rstn(rstn),
	.mem_addr(mem_addr),
	.mem_width(mem_width),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_ok(mem_ok)
);

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
	import arm_pkg::*;

	localparam word_t reset_pc = 32'h0800_0000;	// the preamble's r10 matches this
	localparam int clk_period = 10;
	localparam int mem_words = 1024;
	localparam int res_off = 'h800;	// result area, relative to reset_pc
	localparam word_t nop = 32'he1a0_0000;	// mov r0, r0
	localparam word_t halt = 32'heaff_fffe;	// b .

	typedef struct packed {
		logic [11:0] a;	// shifter operand of mov r1
		logic [11:0] b;	// shifter operand of mov r2
		word_t       ia;
		word_t       ib;
		word_t       exp;
		logic        rel;	// exp is an offset from the row's first instruction
	} row_t;

	logic   clk;
	logic   rstn;
	word_t  mem_addr;
	word_t  mem_wdata;
	word_t  mem_rdata;
	width_t mem_width;
	logic   mem_read;
	logic   mem_write;
	logic   mem_ok;

	word_t mem [0:mem_words-1];
	row_t  rows [$];
	int    n_rows;
	int    errors;
	int    results;
	int    total;
	int    seed;
	int    wait_cnt;
	logic  busy;
	logic  first_seen;
	logic  in_reset;

	tb_clock #(.period(clk_period)) u_clk (.clk(clk));

	cpu_top #(
		.reset_pc(reset_pc)
	) u_dut (
		.clk(clk),
		.rstn(rstn),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_width(mem_width),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_ok(mem_ok)
	);

	function automatic word_t dp_imm(input logic [3:0] c, input logic [3:0] op, input logic s,
		input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] imm);
		return {c, 3'b001, op, s, rn, rd, imm};
	endfunction

	function automatic word_t dp_reg(input logic [3:0] c, input logic [3:0] op, input logic s,
		input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm,
		input logic [1:0] sh, input logic [4:0] amt);
		return {c, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
	endfunction

	// pre-indexed, no writeback; reg_off puts rm in off[3:0]
	function automatic word_t ldst(input logic load, input logic byte_acc, input logic up,
		input logic reg_off, input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] off);
		return {4'he, 2'b01, reg_off, 1'b1, up, byte_acc, 1'b0, load, rn, rd, off};
	endfunction

	function automatic word_t alu_rr(input logic [3:0] op, input logic s);
		return dp_reg(cond_al, op, s, 4'd1, 4'd3, 4'd2, 2'd0, 5'd0);	// r3 = r1 op r2
	endfunction

	function automatic word_t mov_if(input logic [3:0] c);
		return dp_imm(c, op_mov, 1'b0, 4'd0, 4'd3, 12'h001);
	endfunction

	function automatic word_t mov_sh(input logic [1:0] sh, input logic [4:0] amt);
		return dp_reg(cond_al, op_mov, 1'b0, 4'd0, 4'd3, 4'd1, sh, amt);
	endfunction

	function automatic word_t row_addr(input int i);
		return reset_pc + 4 * (2 + 6 * i);
	endfunction

	function automatic logic in_mem(input word_t addr);
		return addr >= reset_pc && addr < reset_pc + 4 * mem_words;
	endfunction

	// byte reads return the addressed byte in the low lane
	function automatic word_t read_data(input word_t addr, input width_t width);
		word_t w;
		w = mem[(addr - reset_pc) >> 2];
		if (width == w_byte)
			return {24'b0, w[8 * addr[1:0] +: 8]};
		return w;
	endfunction

	task automatic add_row(input logic [11:0] a, input logic [11:0] b, input word_t ia,
		input word_t ib, input word_t exp, input logic rel = 1'b0);
		row_t r;
		r = {a, b, ia, ib, exp, rel};
		rows.push_back(r);
	endtask

	task automatic build_table();
		word_t cmp12;
		word_t cmp21;
		word_t adds;
		word_t st;
		cmp12 = dp_reg(cond_al, op_cmp, 1'b1, 4'd1, 4'd0, 4'd2, 2'd0, 5'd0);
		cmp21 = dp_reg(cond_al, op_cmp, 1'b1, 4'd2, 4'd0, 4'd1, 2'd0, 5'd0);
		adds = dp_reg(cond_al, op_add, 1'b1, 4'd1, 4'd0, 4'd2, 2'd0, 5'd0);
		st = ldst(1'b0, 1'b0, 1'b1, 1'b0, 4'd10, 4'd1, 12'h600);	// scratch word
		// all sixteen opcodes with r3 preset to 0xa5
		add_row(12'h0f0, 12'h03c, alu_rr(op_and, 1'b0), nop, 32'h0000_0030);
		add_row(12'h0f0, 12'h03c, alu_rr(op_eor, 1'b0), nop, 32'h0000_00cc);
		add_row(12'h010, 12'h003, alu_rr(op_sub, 1'b0), nop, 32'h0000_000d);
		add_row(12'h010, 12'h003, alu_rr(op_rsb, 1'b0), nop, 32'hffff_fff3);
		add_row(12'h010, 12'h003, dp_imm(cond_al, op_add, 1'b0, 4'd1, 4'd3, 12'hb01), nop,
			32'h0000_0410);
		add_row(12'h010, 12'h003, cmp12, alu_rr(op_adc, 1'b0), 32'h0000_0014);
		add_row(12'h010, 12'h003, cmp21, alu_rr(op_sbc, 1'b0), 32'h0000_000c);
		add_row(12'h010, 12'h003, cmp21, alu_rr(op_rsc, 1'b0), 32'hffff_fff2);
		add_row(12'h0f0, 12'h03c, alu_rr(op_tst, 1'b1), nop, 32'h0000_00a5);
		add_row(12'h0f0, 12'h03c, alu_rr(op_teq, 1'b1), nop, 32'h0000_00a5);
		add_row(12'h0f0, 12'h03c, alu_rr(op_cmp, 1'b1), nop, 32'h0000_00a5);
		add_row(12'h0f0, 12'h03c, alu_rr(op_cmn, 1'b1), nop, 32'h0000_00a5);
		add_row(12'h0f0, 12'h03c, alu_rr(op_orr, 1'b0), nop, 32'h0000_00fc);
		add_row(12'h0f0, 12'h03c, alu_rr(op_mov, 1'b0), nop, 32'h0000_003c);
		add_row(12'h0f0, 12'h03c, alu_rr(op_bic, 1'b0), nop, 32'h0000_00c0);
		add_row(12'h0f0, 12'h03c, alu_rr(op_mvn, 1'b0), nop, 32'hffff_ffc3);
		// r3 becomes 1 where the conditional mov ran
		add_row(12'h005, 12'h005, cmp12, mov_if(cond_eq), 32'h0000_0001);
		add_row(12'h005, 12'h005, cmp12, mov_if(cond_ne), 32'h0000_00a5);
		add_row(12'h4ff, 12'h401, adds, mov_if(cond_cs), 32'h0000_0001);	// 0 with carry
		add_row(12'h003, 12'h005, cmp12, mov_if(cond_cc), 32'h0000_0001);
		add_row(12'h003, 12'h005, cmp12, mov_if(cond_mi), 32'h0000_0001);
		add_row(12'h47f, 12'h47f, adds, mov_if(cond_pl), 32'h0000_00a5);	// signed overflow
		add_row(12'h47f, 12'h47f, adds, mov_if(cond_vs), 32'h0000_0001);
		add_row(12'h4ff, 12'h401, adds, mov_if(cond_vc), 32'h0000_0001);
		add_row(12'h005, 12'h003, cmp12, mov_if(cond_hi), 32'h0000_0001);
		add_row(12'h005, 12'h005, cmp12, mov_if(cond_ls), 32'h0000_0001);
		add_row(12'h47f, 12'h47f, adds, mov_if(cond_ge), 32'h0000_0001);
		add_row(12'h003, 12'h005, cmp12, mov_if(cond_lt), 32'h0000_0001);
		add_row(12'h003, 12'h005, cmp12, mov_if(cond_gt), 32'h0000_00a5);
		add_row(12'h4ff, 12'h401, adds, mov_if(cond_le), 32'h0000_0001);
		// shifted register operand of mov r3, r1
		add_row(12'h00f, 12'h000, mov_sh(2'd0, 5'd4), nop, 32'h0000_00f0);
		add_row(12'h0ab, 12'h000, mov_sh(2'd0, 5'd0), nop, 32'h0000_00ab);
		add_row(12'h0f0, 12'h000, mov_sh(2'd1, 5'd4), nop, 32'h0000_000f);
		add_row(12'h4f0, 12'h000, mov_sh(2'd1, 5'd0), nop, 32'h0000_0000);
		add_row(12'h4f0, 12'h000, mov_sh(2'd2, 5'd4), nop, 32'hff00_0000);
		add_row(12'h4f0, 12'h000, mov_sh(2'd2, 5'd0), nop, 32'hffff_ffff);
		add_row(12'h0ab, 12'h000, mov_sh(2'd3, 5'd8), nop, 32'hab00_0000);
		add_row(12'h002, 12'h000, cmp12, mov_sh(2'd3, 5'd0), 32'h8000_0001);	// rrx with c set
		add_row(12'h003, 12'h001, dp_reg(cond_al, op_add, 1'b0, 4'd2, 4'd3, 4'd1, 2'd0, 5'd2),
			nop, 32'h0000_000d);
		// word store, then byte and word loads of the same address
		add_row(12'hfff, 12'h000, st, ldst(1'b1, 1'b1, 1'b1, 1'b0, 4'd10, 4'd3, 12'h600),
			32'h0000_00fc);
		add_row(12'hfff, 12'h000, st, ldst(1'b1, 1'b0, 1'b0, 1'b0, 4'd12, 4'd3, 12'h100),
			32'h0000_03fc);
		add_row(12'h3ff, 12'hc06, st, ldst(1'b1, 1'b1, 1'b1, 1'b1, 4'd10, 4'd3, 12'h002),
			32'h0000_0003);
		add_row(12'h3ff, 12'hc01, st, ldst(1'b1, 1'b0, 1'b0, 1'b1, 4'd12, 4'd3, 12'h002),
			32'hfc00_0003);
		// b over a poisoned mov, then bl into the next slot
		add_row(12'h000, 12'h000, 32'hea00_0000, dp_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd3,
			12'h0ee), 32'h0000_00a5);
		add_row(12'h000, 12'h000, 32'hebff_ffff, dp_reg(cond_al, op_mov, 1'b0, 4'd0, 4'd3,
			4'd14, 2'd0, 5'd0), 32'd16, 1'b1);
	endtask

	task automatic load_program();
		int base;
		for (int i = 0; i < mem_words; i++)
			mem[i] = ~(reset_pc + 4 * i);	// never-condition words
		mem[0] = dp_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd10, 12'h408);	// r10 = 0x0800_0000
		mem[1] = dp_imm(cond_al, op_add, 1'b0, 4'd10, 4'd12, 12'hc07);	// r12 = r10 + 0x700
		for (int i = 0; i < n_rows; i++) begin
			base = 2 + 6 * i;
			mem[base] = dp_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd1, rows[i].a);
			mem[base + 1] = dp_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd2, rows[i].b);
			mem[base + 2] = dp_imm(cond_al, op_mov, 1'b0, 4'd0, 4'd3, 12'h0a5);
			mem[base + 3] = rows[i].ia;
			mem[base + 4] = rows[i].ib;
			mem[base + 5] = ldst(1'b0, 1'b0, 1'b1, 1'b0, 4'd10, 4'd3, 12'(res_off + 4 * i));
		end
		mem[2 + 6 * n_rows] = halt;
	endtask

	task automatic store_word(input word_t addr, input word_t data, input width_t width);
		int    idx;
		word_t expected;
		assert (in_mem(addr)) else begin
			errors++;
			$display("%0t: store to %h lies outside the memory model", $time, addr);
		end
		if (in_mem(addr)) begin
			idx = (addr - reset_pc) >> 2;
			if (width == w_byte)
				mem[idx][8 * addr[1:0] +: 8] = data[7:0];
			else
				mem[idx] = data;
		end
		if (in_mem(addr) && addr >= reset_pc + res_off) begin
			idx = (addr - reset_pc - res_off) >> 2;
			assert (idx < n_rows) else begin
				errors++;
				$display("%0t: store to %h is past the last result slot", $time, addr);
			end
			if (idx < n_rows) begin
				expected = rows[idx].rel ? row_addr(idx) + rows[idx].exp : rows[idx].exp;
				assert (data == expected) else begin
					errors++;
					$display("FAILED %0t: mem_wdata row %0d expected %h got %h",
						$time, idx, expected, data);
				end
				results++;
			end
		end
	endtask

	// memory model answering after 0 to 3 wait cycles
	always @(posedge clk) begin
		in_reset = !rstn;
		#1;
		mem_ok = 1'b0;
		if (in_reset) begin
			assert (!mem_read && !mem_write) else begin
				errors++;
				$display("%0t: a bus strobe is high during reset", $time);
			end
		end else if (mem_read || mem_write) begin
			if (!first_seen) begin
				first_seen = 1'b1;
				assert (mem_read && mem_addr == reset_pc) else begin
					errors++;
					$display("FAILED %0t: mem_addr expected %h got %h",
						$time, reset_pc, mem_addr);
				end
			end
			if (!busy) begin
				busy = 1'b1;
				wait_cnt = {$random(seed)} % 4;
			end
			if (wait_cnt > 0) begin
				wait_cnt--;
			end else begin
				busy = 1'b0;
				mem_ok = 1'b1;
				if (mem_read) begin
					assert (in_mem(mem_addr)) else begin
						errors++;
						$display("%0t: read of %h lies outside the memory model", $time, mem_addr);
					end
					mem_rdata = in_mem(mem_addr) ? read_data(mem_addr, mem_width) : '0;
				end else begin
					store_word(mem_addr, mem_wdata, mem_width);
				end
			end
		end
	end

	initial begin
		seed = 7;
		errors = 0;
		results = 0;
		wait_cnt = 0;
		busy = 1'b0;
		first_seen = 1'b0;
		rstn = 1'b0;
		mem_ok = 1'b0;
		mem_rdata = '0;
		build_table();
		n_rows = rows.size();
		load_program();
		repeat (2) @(posedge clk);
		#1 rstn = 1'b1;
		wait (results >= n_rows);
		repeat (4) @(posedge clk);
		total = errors + u_dut.u_sva.fails;
		$display("checks failed: %0d, assertion failures: %0d, results: %0d of %0d",
			errors, u_dut.u_sva.fails, results, n_rows);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog allowing 40 cycles a row
	initial begin
		#1;
		#((n_rows * 40 + 300) * clk_period);
		errors++;
		$display("timeout: only %0d of %0d results were stored", results, n_rows);
		$display("checks failed: %0d, assertion failures: %0d", errors, u_dut.u_sva.fails);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/arm_pkg.sv
source/reg_file.sv
source/dp_unit.sv
source/ls_unit.sv
source/cpu_control.sv
source/cpu_top.sv
tests/tb_clock.sv
tests/cpu_sva.sv
tests/cpu_tb.sv
